// File: source/accel_pkg.sv
// ----------------------------------------------------------
// shared constants and the reader phase type for the dual
// accelerometer capture path, referenced by scoped names
// ----------------------------------------------------------
package accel_pkg;

  // spi pacing
  localparam int tick_div = 4;                       // clk cycles per clk_en strobe
  localparam int div_w    = $clog2(tick_div);        // tick counter width

  // transfer length, command byte included
  localparam int seq_max_len = 10;
  localparam int len_w       = $clog2(seq_max_len + 1);  // width of len
  localparam int tick_w      = $clog2(seq_max_len * 16); // two ticks per bit, 8 bits per byte

  // host visible byte buffer
  localparam int buf_depth = 256;
  localparam int buf_aw    = $clog2(buf_depth);      // 8-bit address, wraps

  // sensor one bytes parked until the drain phase
  localparam int side_depth = 12;
  localparam int side_aw    = $clog2(side_depth);

  // axis word layout, 20 bits packed into 3 bytes
  localparam int bytes_per_axis  = 3;                // last byte dropped in 16-bit mode
  localparam int axis_first_byte = 1;                // byte 0 is the command

  // reader sequence phase
  typedef enum logic [2:0] {
    idle,      // waiting for sync, grant may change here only
    select,    // cmd latched, csn falls on next clk_en
    shift,     // command out and data in
    deselect,  // one tick before csn rises
    drain      // replay of sensor one side buffer
  } reader_phase_t;

endpackage

// File: source/spi_tick_gen.sv
// ----------------------------------------------------------
// clock enable for the spi engine, one clk wide strobe
// every tick_div cycles
// ----------------------------------------------------------
`timescale 1ns/10ps

module spi_tick_gen (
  input  logic clk,
  input  logic arst_n,
  output logic clk_en   // registered, first pulse tick_div cycles after reset
);

  logic [accel_pkg::div_w-1:0] cnt;  // free running modulo counter

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt    <= '0;
      clk_en <= 1'b0;
    end
    else
    begin
      cnt    <= cnt + 1'b1;  // natural wrap at tick_div
      clk_en <= (cnt == (accel_pkg::div_w)'(accel_pkg::tick_div - 1));
    end
  end

endmodule

// File: source/accel_spi_reader.sv
// ----------------------------------------------------------
// spi read sequencer for two sensors on one bus that shifts
// the command out and both data lines in and emits strobes
// ----------------------------------------------------------
`timescale 1ns/10ps

module accel_spi_reader (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic                          clk_en,  // bit pacing strobe
  input  logic                          sync,    // start request
  input  logic                          hold,    // direct access granted
  input  logic [7:0]                    cmd,
  input  logic [accel_pkg::len_w-1:0]   len,     // bytes incl. command
  input  logic                          miso0,
  input  logic                          miso1,
  output logic                          sclk,
  output logic                          csn,
  output logic                          mosi,
  output accel_pkg::reader_phase_t      phase,
  output logic [7:0]                    wrdata,
  output logic                          wr,      // every data byte of sensor zero
  output logic                          wr16,    // 16-bit subset plus drain replay
  output logic                          x        // start of x axis word
);

  logic [7:0]                    cmd_q;
  logic [accel_pkg::len_w-1:0]   len_q;
  logic [accel_pkg::tick_w-1:0]  tick_idx;   // running tick within the shift phase
  logic [accel_pkg::tick_w-5:0]  byte_idx;
  logic [7:0]                    mosi_sr;
  logic [6:0]                    sr0;        // last seven bits from sensor zero
  logic [6:0]                    sr1;        // last seven bits from sensor one
  logic [1:0]                    axis_pos;   // byte position inside axis word
  logic [7:0]                    side_mem [accel_pkg::side_depth];
  logic [accel_pkg::side_aw-1:0] side_wptr;
  logic [accel_pkg::side_aw-1:0] side_rptr;
  logic                          start;
  logic                          rise;
  logic                          fall;
  logic                          byte_done;
  logic                          data_byte;
  logic                          keep16;
  logic                          last_bit;
  logic                          side_push;
  logic                          side_pop;

  assign byte_idx  = tick_idx[accel_pkg::tick_w-1:4];
  assign start     = (phase == accel_pkg::idle) && sync && !hold;  // sync while busy is lost
  assign rise      = clk_en && (phase == accel_pkg::shift) && !tick_idx[0]; // sclk goes high
  assign fall      = clk_en && (phase == accel_pkg::shift) && tick_idx[0];
  assign byte_done = rise && (tick_idx[3:1] == 3'd7);   // eighth bit sampled
  assign data_byte = byte_done && (byte_idx != '0);      // command slot is not stored
  assign keep16    = (axis_pos != 2'(accel_pkg::bytes_per_axis - 1)); // drop low byte
  assign last_bit  = fall && (tick_idx[3:1] == 3'd7) && (byte_idx == len_q - 1'b1);
  assign side_push = data_byte && keep16 &&
                     (side_wptr < (accel_pkg::side_aw)'(accel_pkg::side_depth));
  assign side_pop  = clk_en && (phase == accel_pkg::drain) && (side_rptr != side_wptr);
  assign mosi      = mosi_sr[7];  // msb first

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      phase     <= accel_pkg::idle;
      csn       <= 1'b1;
      sclk      <= 1'b0;
      mosi_sr   <= '0;
      tick_idx  <= '0;
      axis_pos  <= '0;
      side_wptr <= '0;
      side_rptr <= '0;
      wr        <= 1'b0;
      wr16      <= 1'b0;
      x         <= 1'b0;
    end
    else
    begin
      wr   <= 1'b0;  // strobes last one clk
      wr16 <= 1'b0;
      x    <= 1'b0;
      case (phase)
        accel_pkg::idle:
          if (start)
            phase <= accel_pkg::select;
        accel_pkg::select:
          if (clk_en)
          begin
            if (hold)
              phase <= accel_pkg::idle;  // grant came with the sync so the bus stays untouched
            else
            begin
              csn       <= 1'b0;
              mosi_sr   <= cmd_q;        // first bit valid before first rising sclk
              tick_idx  <= '0;
              axis_pos  <= '0;
              side_wptr <= '0;
              side_rptr <= '0;
              phase     <= accel_pkg::shift;
            end
          end
        accel_pkg::shift:
          if (clk_en)
          begin
            tick_idx <= tick_idx + 1'b1;
            sclk     <= !tick_idx[0];    // low half then high half
            if (fall)
              mosi_sr <= {mosi_sr[6:0], 1'b0};
            if (data_byte)
            begin
              wr       <= 1'b1;
              wr16     <= keep16;
              x        <= (byte_idx == (accel_pkg::tick_w-4)'(accel_pkg::axis_first_byte));
              axis_pos <= keep16 ? axis_pos + 2'd1 : 2'd0;
            end
            if (side_push)
              side_wptr <= side_wptr + 1'b1;
            if (last_bit)
              phase <= accel_pkg::deselect;
          end
        accel_pkg::deselect:
          if (clk_en)
          begin
            csn   <= 1'b1;               // one tick after the last bit
            phase <= accel_pkg::drain;
          end
        accel_pkg::drain:
          if (side_pop)
          begin
            wr16      <= 1'b1;           // sensor one lands after sensor zero
            side_rptr <= side_rptr + 1'b1;
          end
          else if (clk_en)
            phase <= accel_pkg::idle;
        default:
          phase <= accel_pkg::idle;
      endcase
    end
  end

  // shift registers, side buffer and write data
  always_ff @(posedge clk)
  begin
    if (start)
    begin
      cmd_q <= cmd;
      if (len == '0)
        len_q <= (accel_pkg::len_w)'(1);  // at least the command byte
      else if (len > (accel_pkg::len_w)'(accel_pkg::seq_max_len))
        len_q <= (accel_pkg::len_w)'(accel_pkg::seq_max_len);
      else
        len_q <= len;
    end
    if (rise)
    begin
      sr0 <= {sr0[5:0], miso0};
      sr1 <= {sr1[5:0], miso1};
    end
    if (data_byte)
      wrdata <= {sr0, miso0};          // completed sensor zero byte
    else if (side_pop)
      wrdata <= side_mem[side_rptr];
    if (side_push)
      side_mem[side_wptr] <= {sr1, miso1};
  end

  // outside the drain replay wr16 only comes with wr
  a_wr16_with_wr: assert property (@(posedge clk) disable iff (!arst_n)
    (wr16 && !wr) |-> ($past(phase) == accel_pkg::drain));

  // chip select is released before the reader reports idle
  a_csn_idle: assert property (@(posedge clk) disable iff (!arst_n)
    (phase == accel_pkg::idle) |-> csn);

endmodule

// File: source/direct_access_arbiter.sv
// ----------------------------------------------------------
// grants the host direct control of the sensor pins between
// reader sequences and muxes sclk, csn and mosi
// ----------------------------------------------------------
`timescale 1ns/10ps

module direct_access_arbiter (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     direct,     // async host request
  input  accel_pkg::reader_phase_t phase,
  input  logic                     rd_sclk,
  input  logic                     rd_csn,
  input  logic                     rd_mosi,
  input  logic                     host_sclk,
  input  logic                     host_csn,
  input  logic                     host_mosi,
  output logic                     direct_en,  // grant, also holds the reader
  output logic                     adxl_sclk,
  output logic                     adxl_csn,
  output logic                     adxl_mosi
);

  logic req_s1;  // two flop sync
  logic req_s2;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      req_s1    <= 1'b0;
      req_s2    <= 1'b0;
      direct_en <= 1'b0;
    end
    else
    begin
      req_s1 <= direct;
      req_s2 <= req_s1;
      if (phase == accel_pkg::idle)
        direct_en <= req_s2;  // switch only between sequences
    end
  end

  // miso needs no mux, both sides listen
  assign adxl_sclk = direct_en ? host_sclk : rd_sclk;
  assign adxl_csn  = direct_en ? host_csn  : rd_csn;
  assign adxl_mosi = direct_en ? host_mosi : rd_mosi;

  a_grant_idle: assert property (@(posedge clk) disable iff (!arst_n)
    $changed(direct_en) |-> ($past(phase) == accel_pkg::idle));

endmodule

// File: source/sample_buffer.sv
// ----------------------------------------------------------
// capture byte memory, written by the reader strobes and read
// back by the host with one cycle latency
// ----------------------------------------------------------
`timescale 1ns/10ps

module sample_buffer (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        mode16,   // static during a transfer
  input  logic [7:0]                  wrdata,
  input  logic                        wr,
  input  logic                        wr16,
  input  logic                        x,
  input  logic [accel_pkg::buf_aw-1:0] rd_addr,
  output logic [7:0]                  rd_data,
  output logic [accel_pkg::buf_aw-1:0] wr_ptr,   // next free byte
  output logic [accel_pkg::buf_aw-1:0] x_addr    // where the newest x axis starts
);

  logic [7:0] mem [accel_pkg::buf_depth];
  logic       we;

  // full bytes or the 16-bit subset
  assign we = mode16 ? wr16 : wr;

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      x_addr <= '0;
    end
    else
    begin
      if (we)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at buf_depth, no back-pressure
      if (x)
        x_addr <= wr_ptr;         // address of the byte written now
    end
  end

  always_ff @(posedge clk)
  begin
    if (we)
      mem[wr_ptr] <= wrdata;
    rd_data <= mem[rd_addr];    // registered read
  end

  // reader marks x only on a stored sensor zero byte
  a_x_on_write: assert property (@(posedge clk) disable iff (!arst_n)
    x |-> (wr && wr16));

endmodule

// File: source/accel_capture_top.sv
// ----------------------------------------------------------
// capture front end top, tick generator, spi reader, direct
// access arbiter and sample buffer wired to the pins
// ----------------------------------------------------------
`timescale 1ns/10ps

module accel_capture_top (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         sync,
  input  logic [7:0]                   cmd,
  input  logic [accel_pkg::len_w-1:0]  len,
  input  logic                         direct,
  input  logic                         mode16,
  input  logic                         host_sclk,
  input  logic                         host_csn,
  input  logic                         host_mosi,
  output logic                         adxl_sclk,
  output logic                         adxl_csn,
  output logic                         adxl_mosi,
  input  logic                         adxl0_miso,
  input  logic                         adxl1_miso,
  output logic                         direct_en,
  output logic                         busy,
  input  logic [accel_pkg::buf_aw-1:0] rd_addr,
  output logic [7:0]                   rd_data,
  output logic [accel_pkg::buf_aw-1:0] wr_ptr,
  output logic [accel_pkg::buf_aw-1:0] x_addr
);

  logic                     clk_en;
  logic                     rd_sclk;  // reader side pins before the mux
  logic                     rd_csn;
  logic                     rd_mosi;
  accel_pkg::reader_phase_t phase;
  logic [7:0]               wrdata;
  logic                     wr;
  logic                     wr16;
  logic                     x;

  assign busy = (phase != accel_pkg::idle);

  spi_tick_gen u_tick (.clk(clk), .arst_n(arst_n), .clk_en(clk_en));

  accel_spi_reader u_reader (
    .clk(clk), .arst_n(arst_n), .clk_en(clk_en), .sync(sync), .hold(direct_en),
    .cmd(cmd), .len(len), .miso0(adxl0_miso), .miso1(adxl1_miso),
    .sclk(rd_sclk), .csn(rd_csn), .mosi(rd_mosi), .phase(phase),
    .wrdata(wrdata), .wr(wr), .wr16(wr16), .x(x)
  );

  direct_access_arbiter u_arb (
    .clk(clk), .arst_n(arst_n), .direct(direct), .phase(phase),
    .rd_sclk(rd_sclk), .rd_csn(rd_csn), .rd_mosi(rd_mosi),
    .host_sclk(host_sclk), .host_csn(host_csn), .host_mosi(host_mosi),
    .direct_en(direct_en), .adxl_sclk(adxl_sclk), .adxl_csn(adxl_csn),
    .adxl_mosi(adxl_mosi)
  );

  sample_buffer u_buf (
    .clk(clk), .arst_n(arst_n), .mode16(mode16), .wrdata(wrdata),
    .wr(wr), .wr16(wr16), .x(x), .rd_addr(rd_addr), .rd_data(rd_data),
    .wr_ptr(wr_ptr), .x_addr(x_addr)
  );

endmodule

// File: tb/adxl_pair_model.sv
// ----------------------------------------------------------
// two spi sensors on one bus, answer byte k with a fixed
// pattern each and record the command bits seen on mosi
// ----------------------------------------------------------
`timescale 1ns/10ps

module adxl_pair_model (
  input  logic       sclk,
  input  logic       csn,
  input  logic       mosi,
  output logic       miso0,
  output logic       miso1,
  output logic [7:0] cmd_seen   // first byte clocked in after csn fell
);

  int         nfall    = 0;     // falling sclk edges since select
  logic [7:0] shift_in = '0;
  logic [7:0] ans0;             // sensor zero answer for the current byte
  logic [7:0] ans1;
  logic [2:0] pos;              // bit on the line, msb first

  // csn high restarts the byte count
  always @(negedge sclk or posedge csn)
  begin
    if (csn)
      nfall <= 0;
    else
      nfall <= nfall + 1;       // next bit goes out on falling sclk
  end

  always @(posedge sclk)
  begin
    if (!csn && nfall < 8)
      shift_in <= {shift_in[6:0], mosi};  // command byte only
  end

  assign ans0     = 8'h40 + 8'(nfall / 8);
  assign ans1     = 8'h80 + 8'(nfall / 8);
  assign pos      = 3'(7 - nfall % 8);
  assign miso0    = csn ? 1'b0 : ans0[pos];
  assign miso1    = csn ? 1'b0 : ans1[pos];
  assign cmd_seen = shift_in;

endmodule

// File: tb/accel_capture_tb.sv
// ----------------------------------------------------------
// directed testbench that runs read sequences against the
// sensor model and reads the capture buffer back for checking
// ----------------------------------------------------------
`timescale 1ns/10ps

module accel_capture_tb;

  localparam int clk_period = 4;
  localparam int seq_ticks  = accel_pkg::seq_max_len * 16 + accel_pkg::side_depth + 8;
  localparam int n_seq      = 5;   // sequences started over all tests
  localparam int idle_limit = seq_ticks * accel_pkg::tick_div;  // clk cycles
  localparam int wd_time    = n_seq * idle_limit * clk_period * 2 + 2000;

  logic                         clk;
  logic                         arst_n;
  logic                         sync;
  logic [7:0]                   cmd;
  logic [accel_pkg::len_w-1:0]  len;
  logic                         direct;
  logic                         mode16;
  logic                         host_sclk;
  logic                         host_csn;
  logic                         host_mosi;
  logic                         adxl_sclk;
  logic                         adxl_csn;
  logic                         adxl_mosi;
  logic                         adxl0_miso;
  logic                         adxl1_miso;
  logic                         direct_en;
  logic                         busy;
  logic [accel_pkg::buf_aw-1:0] rd_addr;
  logic [7:0]                   rd_data;
  logic [accel_pkg::buf_aw-1:0] wr_ptr;
  logic [accel_pkg::buf_aw-1:0] x_addr;
  logic [7:0]                   cmd_seen;  // command as the sensors saw it
  logic [accel_pkg::buf_aw-1:0] exp_ptr;   // where the next captured byte should land
  int                           errors;
  int                           checks;

  accel_capture_top UUT (
    .clk(clk), .arst_n(arst_n), .sync(sync), .cmd(cmd), .len(len),
    .direct(direct), .mode16(mode16),
    .host_sclk(host_sclk), .host_csn(host_csn), .host_mosi(host_mosi),
    .adxl_sclk(adxl_sclk), .adxl_csn(adxl_csn), .adxl_mosi(adxl_mosi),
    .adxl0_miso(adxl0_miso), .adxl1_miso(adxl1_miso),
    .direct_en(direct_en), .busy(busy), .rd_addr(rd_addr), .rd_data(rd_data),
    .wr_ptr(wr_ptr), .x_addr(x_addr)
  );

  adxl_pair_model model (
    .sclk(adxl_sclk), .csn(adxl_csn), .mosi(adxl_mosi),
    .miso0(adxl0_miso), .miso1(adxl1_miso), .cmd_seen(cmd_seen)
  );

  initial
  begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // hard stop in case a sequence never ends
  initial
  begin
    #(wd_time);
    $display("watchdog expired, the tests did not finish in %0d ns", wd_time);
    $display("Something failed");
    $finish;
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("ERR %0d ns: %s, got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // inputs change 1 ns after the rising edge where outputs are stable
  task automatic next_cycle;
    @(posedge clk);
    #1;
  endtask

  // in 16-bit mode the last byte of each axis word is dropped
  function automatic bit keeps16(input int k);
    int pos;
    pos = (k - accel_pkg::axis_first_byte) % accel_pkg::bytes_per_axis;
    return pos != accel_pkg::bytes_per_axis - 1;
  endfunction

  task automatic start_seq(input logic [7:0] c, input int l);
    cmd  = c;
    len  = (accel_pkg::len_w)'(l);
    sync = 1'b1;                  // one cycle sync pulse
    next_cycle();
    sync = 1'b0;
  endtask

  // a grant must never show up while the reader is busy
  task automatic wait_idle;
    int n;
    n = 0;
    while (busy && n < idle_limit)
    begin
      check("direct_en while busy", 32'(direct_en), 0);
      next_cycle();
      n++;
    end
    if (busy)
    begin
      errors++;
      $display("reader still busy after %0d cycles", n);
    end
  endtask

  task automatic wait_grant(input logic level);
    int n;
    n = 0;
    while (direct_en !== level && n < 16)
    begin
      next_cycle();
      n++;
    end
    if (direct_en !== level)
    begin
      errors++;
      $display("direct_en did not reach %0b within 16 cycles", level);
    end
  endtask

  task automatic read_byte(input logic [7:0] a, output logic [7:0] d);
    rd_addr = a;
    next_cycle();                 // registered read port
    d = rd_data;
  endtask

  task automatic check_reset_state;
    check("csn after reset", 32'(adxl_csn), 1);
    check("sclk after reset", 32'(adxl_sclk), 0);
    check("direct_en after reset", 32'(direct_en), 0);
    check("busy after reset", 32'(busy), 0);
    check("wr_ptr after reset", 32'(wr_ptr), 0);
  endtask

  // one sequence followed by pointer, marker, command and buffer checks
  task automatic run_capture(input logic [7:0] c, input int l, input logic m16,
                             input bit resync);
    logic [7:0] base;
    logic [7:0] got;
    logic [7:0] exp_q[$];
    int         k;
    int         i;
    mode16 = m16;
    base   = exp_ptr;
    for (k = accel_pkg::axis_first_byte; k < l; k++)
      if (!m16 || keeps16(k))
        exp_q.push_back(8'h40 + 8'(k));   // sensor zero first
    if (m16)
      for (k = accel_pkg::axis_first_byte; k < l; k++)
        if (keeps16(k))
          exp_q.push_back(8'h80 + 8'(k)); // then the side buffer replay
    start_seq(c, l);
    check("busy after sync", 32'(busy), 1);
    if (resync)
    begin
      repeat (8) next_cycle();
      start_seq(c, l);                    // lands mid sequence
    end
    wait_idle();
    repeat (4 * accel_pkg::tick_div) next_cycle();
    check("busy after sequence", 32'(busy), 0);
    check("wr_ptr after sequence", 32'(wr_ptr), 32'(base + 8'(exp_q.size())));
    check("x_addr", 32'(x_addr), 32'(base));
    check("command on mosi", 32'(cmd_seen), 32'(c));
    for (i = 0; i < exp_q.size(); i++)
    begin
      read_byte(base + 8'(i), got);
      check("buffer byte", 32'(got), 32'(exp_q[i]));
    end
    exp_ptr = base + 8'(exp_q.size());
  endtask

  task automatic direct_access;
    mode16 = 1'b0;
    start_seq(8'h0b, 4);
    direct = 1'b1;                        // request while busy
    wait_idle();
    exp_ptr = exp_ptr + 8'(4 - accel_pkg::axis_first_byte);  // data bytes of that sequence
    wait_grant(1'b1);
    host_sclk = 1'b1;
    host_csn  = 1'b0;
    host_mosi = 1'b1;
    next_cycle();
    check("adxl_sclk from host", 32'(adxl_sclk), 1);
    check("adxl_csn from host", 32'(adxl_csn), 0);
    check("adxl_mosi from host", 32'(adxl_mosi), 1);
    host_sclk = 1'b0;
    host_csn  = 1'b1;
    host_mosi = 1'b0;
    next_cycle();
    check("adxl_sclk back low", 32'(adxl_sclk), 0);
    check("adxl_csn back high", 32'(adxl_csn), 1);
    check("adxl_mosi back low", 32'(adxl_mosi), 0);
    start_seq(8'h0b, 4);                  // held off by the grant
    repeat (4 * accel_pkg::tick_div) next_cycle();
    check("busy under grant", 32'(busy), 0);
    check("wr_ptr under grant", 32'(wr_ptr), 32'(exp_ptr));
    direct = 1'b0;
    wait_grant(1'b0);
    run_capture(8'h0b, 4, 1'b0, 1'b0);    // reader works again
  endtask

  initial
  begin
    errors    = 0;
    checks    = 0;
    exp_ptr   = '0;
    arst_n    = 1'b0;
    sync      = 1'b0;
    cmd       = '0;
    len       = '0;
    direct    = 1'b0;
    mode16    = 1'b0;
    host_sclk = 1'b0;
    host_csn  = 1'b1;
    host_mosi = 1'b0;
    rd_addr   = '0;
    repeat (5) @(posedge clk);
    #1;
    arst_n = 1'b1;
    check_reset_state();
    run_capture(8'hf2, 10, 1'b0, 1'b0);   // full bytes
    run_capture(8'hf2, 10, 1'b1, 1'b0);   // 16-bit subset
    run_capture(8'h32, 4, 1'b0, 1'b1);    // short sequence with an extra sync while busy
    direct_access();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

// File: list.f
source/accel_pkg.sv
source/spi_tick_gen.sv
source/accel_spi_reader.sv
source/direct_access_arbiter.sv
source/sample_buffer.sv
source/accel_capture_top.sv
tb/adxl_pair_model.sv
tb/accel_capture_tb.sv

// File: Makefile
# Verilator lint, simulation and cleanup for the capture front end

TOP = accel_capture_tb

lint:
	verilator --lint-only --timing --assert --timescale 1ns/10ps -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/10ps -f list.f \
		--top-module $(TOP) -o accel_sim
	-./obj_dir/accel_sim > sim.log 2>&1
	@cat sim.log
	@if grep -q "Something failed" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: lint sim clean
